// ==== Bender.yml ====
package:
  name: fetch_sys

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/fetch_pkg.sv
      - hdl/fetch_unit.sv
      - hdl/data_port.sv
      - hdl/wb_arbiter.sv
      - hdl/wb_ram.sv
      - hdl/fetch_sys.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/fetch_sys_asserts.sv
      - sim/fetch_sys_tb.sv

// ==== fetch_sys.f ====
+incdir+hdl
hdl/fetch_pkg.sv
hdl/fetch_unit.sv
hdl/data_port.sv
hdl/wb_arbiter.sv
hdl/wb_ram.sv
hdl/fetch_sys.sv
sim/fetch_sys_asserts.sv
sim/fetch_sys_tb.sv

// ==== hdl/data_port.sv ====
// -----------------------------------------------
// data side wishbone master, one request at a time
// response registered until dresp_rdy
// -----------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "fetch_macros.svh"

module data_port (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     dreq_val,
  output logic                     dreq_rdy,
  input  fetch_pkg::dp_op_e        dreq_op,
  input  logic [`FETCH_ADDR_W-1:0] dreq_addr,
  input  logic [`INST_W-1:0]       dreq_wdata,
  output logic                     dresp_val,
  input  logic                     dresp_rdy,
  output logic [`INST_W-1:0]       dresp_rdata,
  output logic                     d_wb_cyc,
  output logic                     d_wb_stb,
  output logic                     d_wb_we,
  output logic [`FETCH_ADDR_W-1:0] d_wb_adr,
  output logic [`INST_W-1:0]       d_wb_dat_w,
  input  logic [`INST_W-1:0]       d_wb_dat_r,
  input  logic                     d_wb_ack
);

  fetch_pkg::dp_op_e op_q;

  // idle means no bus cycle and no pending response
  assign dreq_rdy = ~d_wb_cyc & ~dresp_val;
  assign d_wb_stb = d_wb_cyc;
  assign d_wb_we  = (op_q == fetch_pkg::DP_WRITE);

  // control
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      d_wb_cyc  <= 1'b0;
      dresp_val <= 1'b0;
    end else begin
      if (dreq_val && dreq_rdy) begin
        d_wb_cyc <= 1'b1;
      end else if (d_wb_ack) begin
        // cycle ends, writes answer too
        d_wb_cyc  <= 1'b0;
        dresp_val <= 1'b1;
      end else if (dresp_val && dresp_rdy) begin
        dresp_val <= 1'b0;
      end
    end
  end

  // request and response payload
  always_ff @(posedge clk) begin
    if (dreq_val && dreq_rdy) begin
      op_q       <= dreq_op;
      d_wb_adr   <= dreq_addr;
      d_wb_dat_w <= dreq_wdata;
    end
    if (d_wb_cyc && d_wb_ack) begin
      dresp_rdata <= d_wb_dat_r;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/fetch_macros.svh ====
// -----------------------------------------------
// widths, reset pc and ram depth for the fetch
// subsystem, included by every rtl file
// -----------------------------------------------

`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// byte address width, 4 KiB of word ram
`define FETCH_ADDR_W 12

// ram depth in 32-bit words
`define MEM_WORDS 1024

// first fetch address out of reset
`define RESET_PC 0

// decode sequence number width
`define SEQ_BITS 5

// instruction and bus data width
`define INST_W 32

`endif

// ==== hdl/fetch_pkg.sv ====
// -----------------------------------------------
// state and opcode enums shared by rtl and tb
// -----------------------------------------------

`default_nettype none

package fetch_pkg;

  // fetch engine states
  typedef enum logic [1:0] {
    FS_REQ  = 2'd0,  // bus cycle open
    FS_HOLD = 2'd1,  // output buffer full or gap cycle
    FS_DROP = 2'd2   // stale response after redirect
  } fetch_state_e;

  // arbiter grant state
  typedef enum logic [1:0] {
    ARB_IDLE  = 2'd0,
    ARB_FETCH = 2'd1,
    ARB_DATA  = 2'd2
  } arb_state_e;

  // data port request opcodes
  typedef enum logic {
    DP_READ  = 1'b0,
    DP_WRITE = 1'b1
  } dp_op_e;

endpackage

`default_nettype wire

// ==== hdl/fetch_sys.sv ====
// -----------------------------------------------
// fetch subsystem top: fetch unit and data port
// share one ram through the wishbone arbiter
// -----------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "fetch_macros.svh"

module fetch_sys (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     redirect,
  input  logic [`FETCH_ADDR_W-1:0] redirect_pc,
  output logic                     dec_val,
  input  logic                     dec_rdy,
  output logic [`INST_W-1:0]       dec_inst,
  output logic [`FETCH_ADDR_W-1:0] dec_pc,
  output logic [`SEQ_BITS-1:0]     dec_seq,
  input  logic                     dreq_val,
  output logic                     dreq_rdy,
  input  fetch_pkg::dp_op_e        dreq_op,
  input  logic [`FETCH_ADDR_W-1:0] dreq_addr,
  input  logic [`INST_W-1:0]       dreq_wdata,
  output logic                     dresp_val,
  input  logic                     dresp_rdy,
  output logic [`INST_W-1:0]       dresp_rdata
);

  // fetch master, read only
  logic                     f_wb_cyc, f_wb_stb, f_wb_ack;
  logic [`FETCH_ADDR_W-1:0] f_wb_adr;
  logic [`INST_W-1:0]       f_wb_dat_r;
  // data master
  logic                     d_wb_cyc, d_wb_stb, d_wb_we, d_wb_ack;
  logic [`FETCH_ADDR_W-1:0] d_wb_adr;
  logic [`INST_W-1:0]       d_wb_dat_w, d_wb_dat_r;
  // arbiter to ram
  logic                     s_wb_cyc, s_wb_stb, s_wb_we, s_wb_ack;
  logic [`FETCH_ADDR_W-1:0] s_wb_adr;
  logic [`INST_W-1:0]       s_wb_dat_w, s_wb_dat_r;

  fetch_unit u_fetch (
    .clk, .rst_n, .redirect, .redirect_pc,
    .f_wb_cyc, .f_wb_stb, .f_wb_adr, .f_wb_dat_r, .f_wb_ack,
    .dec_val, .dec_rdy, .dec_inst, .dec_pc, .dec_seq
  );

  data_port u_dport (
    .clk, .rst_n,
    .dreq_val, .dreq_rdy, .dreq_op, .dreq_addr, .dreq_wdata,
    .dresp_val, .dresp_rdy, .dresp_rdata,
    .d_wb_cyc, .d_wb_stb, .d_wb_we, .d_wb_adr, .d_wb_dat_w, .d_wb_dat_r, .d_wb_ack
  );

  wb_arbiter u_arb (
    .clk, .rst_n,
    .f_wb_cyc, .f_wb_stb, .f_wb_adr, .f_wb_dat_r, .f_wb_ack,
    .d_wb_cyc, .d_wb_stb, .d_wb_we, .d_wb_adr, .d_wb_dat_w, .d_wb_dat_r, .d_wb_ack,
    .s_wb_cyc, .s_wb_stb, .s_wb_we, .s_wb_adr, .s_wb_dat_w, .s_wb_dat_r, .s_wb_ack
  );

  wb_ram u_ram (
    .clk, .rst_n,
    .s_wb_cyc, .s_wb_stb, .s_wb_we, .s_wb_adr, .s_wb_dat_w, .s_wb_dat_r, .s_wb_ack
  );

endmodule

`default_nettype wire

// ==== hdl/fetch_unit.sv ====
// -----------------------------------------------
// sequential instruction fetch over a read-only
// wishbone master, one-entry buffer toward decode
// redirect from decode reloads the pc
// -----------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "fetch_macros.svh"

module fetch_unit (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     redirect,
  input  logic [`FETCH_ADDR_W-1:0] redirect_pc,
  output logic                     f_wb_cyc,
  output logic                     f_wb_stb,
  output logic [`FETCH_ADDR_W-1:0] f_wb_adr,
  input  logic [`INST_W-1:0]       f_wb_dat_r,
  input  logic                     f_wb_ack,
  output logic                     dec_val,
  input  logic                     dec_rdy,
  output logic [`INST_W-1:0]       dec_inst,
  output logic [`FETCH_ADDR_W-1:0] dec_pc,
  output logic [`SEQ_BITS-1:0]     dec_seq
);

  fetch_pkg::fetch_state_e state;

  // address of the open or next bus cycle
  logic [`FETCH_ADDR_W-1:0] fetch_pc;
  // target held while a stale cycle drains
  logic [`FETCH_ADDR_W-1:0] redir_pc;
  logic                     xfer;

  // redirect blocks any handoff in its cycle
  assign xfer = dec_val & dec_rdy & ~redirect;

  // cycle stays open through a drop, address frozen
  assign f_wb_cyc = (state == fetch_pkg::FS_REQ) | (state == fetch_pkg::FS_DROP);
  assign f_wb_stb = f_wb_cyc;
  assign f_wb_adr = fetch_pc;

  // -----------------------------------------------
  // control
  // -----------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // gap state first, so cyc stays low in reset
      state    <= fetch_pkg::FS_HOLD;
      dec_val  <= 1'b0;
      fetch_pc <= `FETCH_ADDR_W'(`RESET_PC);
      dec_seq  <= '0;
    end else begin
      if (xfer) begin
        dec_seq <= dec_seq + `SEQ_BITS'(1);
      end
      case (state)
        fetch_pkg::FS_REQ: begin
          if (redirect) begin
            // response in flight is wrong path
            if (f_wb_ack) begin
              fetch_pc <= redirect_pc;
              state    <= fetch_pkg::FS_HOLD;
            end else begin
              state    <= fetch_pkg::FS_DROP;
            end
          end else if (f_wb_ack) begin
            dec_val  <= 1'b1;
            fetch_pc <= fetch_pc + `FETCH_ADDR_W'(4);
            state    <= fetch_pkg::FS_HOLD;
          end
        end
        fetch_pkg::FS_DROP: begin
          // a later redirect wins over the held one
          if (f_wb_ack) begin
            fetch_pc <= redirect ? redirect_pc : redir_pc;
            state    <= fetch_pkg::FS_HOLD;
          end
        end
        default: begin
          // cyc was low this cycle, may open a new one
          if (redirect) begin
            dec_val  <= 1'b0;
            fetch_pc <= redirect_pc;
            state    <= fetch_pkg::FS_REQ;
          end else if (xfer || !dec_val) begin
            dec_val  <= 1'b0;
            state    <= fetch_pkg::FS_REQ;
          end
        end
      endcase
    end
  end

  // -----------------------------------------------
  // payload, written only on a good response
  // -----------------------------------------------
  always_ff @(posedge clk) begin
    if (state == fetch_pkg::FS_REQ && f_wb_ack && !redirect) begin
      dec_inst <= f_wb_dat_r;
      dec_pc   <= fetch_pc;
    end
    if (redirect) begin
      redir_pc <= redirect_pc;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/wb_arbiter.sv ====
// -----------------------------------------------
// round-robin wishbone classic arbiter, fetch and
// data masters onto the single ram slave
// -----------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "fetch_macros.svh"

module wb_arbiter (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     f_wb_cyc,
  input  logic                     f_wb_stb,
  input  logic [`FETCH_ADDR_W-1:0] f_wb_adr,
  output logic [`INST_W-1:0]       f_wb_dat_r,
  output logic                     f_wb_ack,
  input  logic                     d_wb_cyc,
  input  logic                     d_wb_stb,
  input  logic                     d_wb_we,
  input  logic [`FETCH_ADDR_W-1:0] d_wb_adr,
  input  logic [`INST_W-1:0]       d_wb_dat_w,
  output logic [`INST_W-1:0]       d_wb_dat_r,
  output logic                     d_wb_ack,
  output logic                     s_wb_cyc,
  output logic                     s_wb_stb,
  output logic                     s_wb_we,
  output logic [`FETCH_ADDR_W-1:0] s_wb_adr,
  output logic [`INST_W-1:0]       s_wb_dat_w,
  input  logic [`INST_W-1:0]       s_wb_dat_r,
  input  logic                     s_wb_ack
);

  fetch_pkg::arb_state_e state, gnt;
  fetch_pkg::arb_state_e pick;
  // data master had the last grant
  logic                  last_data;
  logic                  gnt_f, gnt_d;

  // both asking, the one not served last wins
  always_comb begin
    if (f_wb_cyc && d_wb_cyc) begin
      pick = last_data ? fetch_pkg::ARB_FETCH : fetch_pkg::ARB_DATA;
    end else if (f_wb_cyc) begin
      pick = fetch_pkg::ARB_FETCH;
    end else if (d_wb_cyc) begin
      pick = fetch_pkg::ARB_DATA;
    end else begin
      pick = fetch_pkg::ARB_IDLE;
    end
  end

  // grant held while owner's cyc high, else re-pick same cycle
  always_comb begin
    case (state)
      fetch_pkg::ARB_FETCH: gnt = f_wb_cyc ? fetch_pkg::ARB_FETCH : pick;
      fetch_pkg::ARB_DATA:  gnt = d_wb_cyc ? fetch_pkg::ARB_DATA : pick;
      default:              gnt = pick;
    endcase
  end

  assign gnt_f = (gnt == fetch_pkg::ARB_FETCH);
  assign gnt_d = (gnt == fetch_pkg::ARB_DATA);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= fetch_pkg::ARB_IDLE;
      last_data <= 1'b0;
    end else begin
      state <= gnt;
      if (gnt != fetch_pkg::ARB_IDLE) begin
        last_data <= gnt_d;
      end
    end
  end

  // slave side mux, fetch never writes
  assign s_wb_cyc   = (gnt_f & f_wb_cyc) | (gnt_d & d_wb_cyc);
  assign s_wb_stb   = (gnt_f & f_wb_stb) | (gnt_d & d_wb_stb);
  assign s_wb_we    = gnt_d & d_wb_we;
  assign s_wb_adr   = gnt_d ? d_wb_adr : f_wb_adr;
  assign s_wb_dat_w = gnt_d ? d_wb_dat_w : '0;

  // responses only to the owner
  assign f_wb_ack   = gnt_f & s_wb_ack;
  assign d_wb_ack   = gnt_d & s_wb_ack;
  assign f_wb_dat_r = gnt_f ? s_wb_dat_r : '0;
  assign d_wb_dat_r = gnt_d ? s_wb_dat_r : '0;

endmodule

`default_nettype wire

// ==== hdl/wb_ram.sv ====
// -----------------------------------------------
// wishbone classic word ram, ack one cycle after
// cyc and stb, read data valid with ack
// -----------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "fetch_macros.svh"

module wb_ram (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     s_wb_cyc,
  input  logic                     s_wb_stb,
  input  logic                     s_wb_we,
  input  logic [`FETCH_ADDR_W-1:0] s_wb_adr,
  input  logic [`INST_W-1:0]       s_wb_dat_w,
  output logic [`INST_W-1:0]       s_wb_dat_r,
  output logic                     s_wb_ack
);

  logic [`INST_W-1:0] mem [0:`MEM_WORDS-1];
  logic               access;
  logic [$clog2(`MEM_WORDS)-1:0] word_idx;

  // new beat only when no ack is out, so back-to-back cycles are seen
  assign access   = s_wb_cyc & s_wb_stb & ~s_wb_ack;
  // byte address to word index
  assign word_idx = s_wb_adr[2 +: $clog2(`MEM_WORDS)];

  // contents power up cleared
  initial begin
    for (int i = 0; i < `MEM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  // single beat ack
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s_wb_ack <= 1'b0;
    end else begin
      s_wb_ack <= access;
    end
  end

  // read returns old word on a write
  always_ff @(posedge clk) begin
    if (access) begin
      s_wb_dat_r <= mem[word_idx];
      if (s_wb_we) begin
        mem[word_idx] <= s_wb_dat_w;
      end
    end
  end

endmodule

`default_nettype wire

// ==== sim/fetch_sys_asserts.sv ====
// --------------------------------------------------
// bus and decode stream protocol rules that the
// testbench binds onto the fetch subsystem top
// --------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "fetch_macros.svh"

module fetch_sys_asserts (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     redirect,
  input logic                     dec_val,
  input logic                     dec_rdy,
  input logic [`INST_W-1:0]       dec_inst,
  input logic [`FETCH_ADDR_W-1:0] dec_pc,
  input logic [`SEQ_BITS-1:0]     dec_seq,
  input logic                     dreq_rdy,
  input logic                     dresp_val,
  input logic                     f_wb_cyc,
  input logic                     d_wb_cyc,
  input logic [`FETCH_ADDR_W-1:0] f_wb_adr,
  input logic [`FETCH_ADDR_W-1:0] d_wb_adr,
  input logic                     f_wb_ack,
  input logic                     d_wb_ack,
  input logic                     s_wb_cyc,
  input logic                     s_wb_stb,
  input logic [`FETCH_ADDR_W-1:0] s_wb_adr,
  input logic                     s_wb_ack
);

  // count of failed rules
  int fail_cnt = 0;

  // ram ack only inside an open cycle
  ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    s_wb_ack |-> (s_wb_cyc && s_wb_stb))
    else begin
      $error("ram ack outside of a bus cycle");
      fail_cnt++;
    end

  // acked master owned the slave during its beat
  single_grant: assert property (@(posedge clk) disable iff (!rst_n)
    (f_wb_ack || d_wb_ack) |-> ($past(s_wb_adr) == (f_wb_ack ? f_wb_adr : d_wb_adr)))
    else begin
      $error("ack went to a master that did not own the ram beat");
      fail_cnt++;
    end

  // stalled item waits unchanged
  dec_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (dec_val && !dec_rdy && !redirect) |=>
      (dec_val && $stable(dec_inst) && $stable(dec_pc) && $stable(dec_seq)))
    else begin
      $error("decode item changed while stalled");
      fail_cnt++;
    end

  // everything quiet on the first clock after reset
  reset_quiet: assert property (@(posedge clk)
    $rose(rst_n) |-> (!dec_val && !dresp_val && dreq_rdy && !f_wb_cyc && !d_wb_cyc))
    else begin
      $error("outputs active after reset");
      fail_cnt++;
    end

endmodule

`default_nettype wire

// ==== sim/fetch_sys_tb.sv ====
// --------------------------------------------------
// testbench for the fetch subsystem that loads a
// program through the data port and then checks the
// decode stream against a word model under traffic
// --------------------------------------------------

`timescale 1ns/1ns
`default_nettype none

`include "fetch_macros.svh"

bind fetch_sys fetch_sys_asserts u_asserts (.*);

module fetch_sys_tb;

  localparam int N_XFERS   = 400;
  localparam int STALL_MAX = 200;
  localparam int WAIT_MAX  = 100;

  logic                     clk;
  logic                     rst_n;
  logic                     redirect;
  logic [`FETCH_ADDR_W-1:0] redirect_pc;
  logic                     dec_val;
  logic                     dec_rdy;
  logic [`INST_W-1:0]       dec_inst;
  logic [`FETCH_ADDR_W-1:0] dec_pc;
  logic [`SEQ_BITS-1:0]     dec_seq;
  logic                     dreq_val;
  logic                     dreq_rdy;
  fetch_pkg::dp_op_e        dreq_op;
  logic [`FETCH_ADDR_W-1:0] dreq_addr;
  logic [`INST_W-1:0]       dreq_wdata;
  logic                     dresp_val;
  logic                     dresp_rdy;
  logic [`INST_W-1:0]       dresp_rdata;

  // word model of the ram
  logic [`INST_W-1:0] model [0:`MEM_WORDS-1];
  // random state for fetch side and data side
  logic [31:0]        lfsr;
  logic [31:0]        lfsr_d;
  logic               fetch_done;

  fetch_sys u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // bound protocol rules end the run on their first failure
  always @(posedge clk) begin
    assert (u_dut.u_asserts.fail_cnt == 0)
      else stall_abort("a bus or stream protocol rule failed");
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one step per bit taken
  task automatic draw_bits(inout logic [31:0] st, input int n, output logic [31:0] val);
    int i;
    val = '0;
    for (i = 0; i < n; i++) begin
      st  = lfsr_step(st);
      val = {val[30:0], st[0]};
    end
  endtask

  task automatic flag_mismatch(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    $display("Fail %0t ns: %s is %h, expected %h", $time, what, got, exp);
    $display("TB FAILED");
    $fatal(1);
  endtask

  task automatic stall_abort(input string msg);
    $display("%0t ns: %s", $time, msg);
    $display("TB FAILED");
    $fatal(1);
  endtask

  // one data port request and its response
  // called right after a clock edge
  task automatic data_access(input fetch_pkg::dp_op_e op, input logic [11:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             inout logic [31:0] st);
    int          waited;
    logic        done;
    logic [31:0] rv;
    dreq_val   <= 1'b1;
    dreq_op    <= op;
    dreq_addr  <= addr;
    dreq_wdata <= wdata;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
    end while (!dreq_rdy && waited < WAIT_MAX);
    assert (dreq_rdy) else stall_abort("data request was never accepted");
    dreq_val <= 1'b0;
    // random response back-pressure
    done   = 1'b0;
    waited = 0;
    while (!done && waited < WAIT_MAX) begin
      draw_bits(st, 1, rv);
      dresp_rdy <= rv[0];
      @(posedge clk);
      waited++;
      done = dresp_val && dresp_rdy;
    end
    dresp_rdy <= 1'b0;
    assert (done) else stall_abort("no data response arrived");
    rdata = dresp_rdata;
    if (op == fetch_pkg::DP_WRITE) begin
      model[addr[11:2]] = wdata;
    end
  endtask

  // --------------------------------------------------
  // phases
  // --------------------------------------------------
  task automatic load_program();
    int          w;
    logic [31:0] rv;
    logic [31:0] rd;
    for (w = 0; w < 64; w++) begin
      draw_bits(lfsr, 32, rv);
      data_access(fetch_pkg::DP_WRITE, 12'(w * 4), rv, rd, lfsr);
    end
  endtask

  task automatic readback_program();
    int          n;
    logic [31:0] rv;
    logic [31:0] rd;
    for (n = 0; n < 32; n++) begin
      draw_bits(lfsr, 6, rv);
      data_access(fetch_pkg::DP_READ, {4'b0, rv[5:0], 2'b00}, '0, rd, lfsr);
      assert (rd == model[rv[5:0]]) else flag_mismatch("program read-back", rd, model[rv[5:0]]);
    end
  endtask

  task automatic fetch_checker();
    int                       count;
    int                       stall;
    logic                     force_redir;
    logic [`FETCH_ADDR_W-1:0] target;
    logic [`FETCH_ADDR_W-1:0] expect_pc;
    logic [`SEQ_BITS-1:0]     expect_seq;
    logic [31:0]              rv;
    count       = 0;
    stall       = 0;
    expect_pc   = '0;
    expect_seq  = '0;
    // start the stream at address 0
    force_redir = 1'b1;
    target      = '0;
    while (count < N_XFERS) begin
      redirect    <= force_redir;
      redirect_pc <= target;
      force_redir = 1'b0;
      draw_bits(lfsr, 2, rv);
      dec_rdy <= |rv[1:0];
      @(posedge clk);
      stall++;
      assert (stall < STALL_MAX) else stall_abort("decode stream stalled");
      if (redirect) begin
        expect_pc = redirect_pc;
      end else if (dec_val && dec_rdy) begin
        assert (dec_pc == expect_pc) else flag_mismatch("dec_pc", dec_pc, expect_pc);
        assert (dec_inst == model[expect_pc[11:2]])
          else flag_mismatch("dec_inst", dec_inst, model[expect_pc[11:2]]);
        assert (dec_seq == expect_seq) else flag_mismatch("dec_seq", dec_seq, expect_seq);
        count++;
        stall = 0;
        // random branch or wrap before leaving the program
        draw_bits(lfsr, 4, rv);
        if (rv[3:0] == 4'd0 || expect_pc[11:2] >= 10'd56) begin
          force_redir = 1'b1;
          draw_bits(lfsr, 6, rv);
          target = {4'b0, rv[5:0], 2'b00};
        end
        expect_pc  = expect_pc + 12'd4;
        expect_seq = expect_seq + 5'd1;
      end
    end
    redirect   <= 1'b0;
    dec_rdy    <= 1'b0;
    fetch_done = 1'b1;
  endtask

  // reads and writes in words 512 to 1023
  task automatic data_traffic();
    logic [31:0]       rv;
    logic [31:0]       wdata;
    logic [31:0]       rd;
    logic [11:0]       addr;
    fetch_pkg::dp_op_e op;
    while (!fetch_done) begin
      draw_bits(lfsr_d, 1, rv);
      op = fetch_pkg::dp_op_e'(rv[0]);
      draw_bits(lfsr_d, 9, rv);
      addr = {1'b1, rv[8:0], 2'b00};
      draw_bits(lfsr_d, 32, wdata);
      data_access(op, addr, wdata, rd, lfsr_d);
      if (op == fetch_pkg::DP_READ) begin
        assert (rd == model[addr[11:2]]) else flag_mismatch("data read", rd, model[addr[11:2]]);
      end
    end
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    rst_n       = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    dec_rdy     = 1'b0;
    dreq_val    = 1'b0;
    dreq_op     = fetch_pkg::DP_READ;
    dreq_addr   = '0;
    dreq_wdata  = '0;
    dresp_rdy   = 1'b0;
    lfsr        = 32'd98716;
    fetch_done  = 1'b0;
    for (int i = 0; i < `MEM_WORDS; i++) begin
      model[i] = '0;
    end

    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    assert (dreq_rdy === 1'b1) else flag_mismatch("dreq_rdy after reset", dreq_rdy, 1);
    assert (dresp_val === 1'b0) else flag_mismatch("dresp_val after reset", dresp_val, 0);

    // decode held off while the program goes in
    load_program();
    readback_program();

    lfsr_d = lfsr_step(lfsr);
    fork
      fetch_checker();
      data_traffic();
    join

    // one more edge so the last protocol rule is counted
    @(posedge clk);
    if (u_dut.u_asserts.fail_cnt == 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      stall_abort("a bus or stream protocol rule failed");
    end
  end

endmodule

`default_nettype wire
